// File: dv/snake_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "snake_defines.svh"

module snake_asserts
    import snake_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input digit_sel_t  digit,
    input seg_mask_t   segments,
    input buttons_t    pulse,
    input game_state_t state
);

    // At most one digit strobe low at a time
    strobe_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(~digit))
        else $error("digit strobe selects more than one digit: %b", digit);

    // Button events last a single cycle
    pulse_single: assert property (@(posedge clk) disable iff (rst)
        (pulse & $past(pulse)) == '0)
        else $error("button pulse stayed high for two cycles: %b", pulse);

    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {INITIAL, MOVING, FALLING})
        else $error("game state left its legal values: %0d", state);

    // Display stays dark through reset and the first edge after it
    reset_blank: assert property (@(posedge clk)
        $past(rst) |-> (digit == '1 && segments == `SEG_BLANK))
        else $error("display not blank after reset: digit %b segments %b", digit, segments);

endmodule

`default_nettype wire

// File: dv/snake_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "snake_defines.svh"

module snake_tb
    import snake_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int TICK_CYCLES = 16;
    localparam int SCAN_CYCLES = 4;
    localparam int SCAN_FULL = SCAN_CYCLES * `DIGIT_COUNT;
    localparam int PRESS_CYCLES = 8;
    localparam int RELEASE_CYCLES = 8;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int NUM_MOVES = 19;
    localparam int NUM_ROWS = 20;

    localparam buttons_t BTN_NONE = 4'b0000;
    localparam buttons_t BTN_TR = 4'b1000;
    localparam buttons_t BTN_TL = 4'b0100;
    localparam buttons_t BTN_FWD = 4'b0010;
    localparam buttons_t BTN_DROP = 4'b0001;

    // Only segment G lit
    localparam seg_mask_t FACE_G = 7'b011_1111;

    typedef struct packed {
        seg_idx_t seg;
        heading_t hd;
        buttons_t btn;
        seg_idx_t new_seg;
        heading_t new_hd;
    } move_t;

    typedef struct packed {
        buttons_t   press;
        logic [3:0] wait_ticks;
    } stim_t;

    typedef struct packed {
        stim_t     stim;
        seg_mask_t face;
        // Bits that take part in the compare
        seg_mask_t care;
    } row_t;

    // Segment, heading, button, then where the snake ends up
    localparam move_t MOVES [NUM_MOVES] = '{
        '{SEG_A, RIGHT, BTN_TR,  SEG_B, DOWN},
        '{SEG_A, LEFT,  BTN_TL,  SEG_F, DOWN},
        '{SEG_B, UP,    BTN_TL,  SEG_A, LEFT},
        '{SEG_B, DOWN,  BTN_TR,  SEG_G, LEFT},
        '{SEG_B, DOWN,  BTN_FWD, SEG_C, DOWN},
        '{SEG_C, UP,    BTN_TL,  SEG_G, LEFT},
        '{SEG_C, UP,    BTN_FWD, SEG_B, UP},
        '{SEG_C, DOWN,  BTN_TR,  SEG_D, LEFT},
        '{SEG_D, RIGHT, BTN_TL,  SEG_C, UP},
        '{SEG_D, LEFT,  BTN_TR,  SEG_E, UP},
        '{SEG_E, UP,    BTN_TR,  SEG_G, RIGHT},
        '{SEG_E, UP,    BTN_FWD, SEG_F, UP},
        '{SEG_E, DOWN,  BTN_TL,  SEG_D, RIGHT},
        '{SEG_F, UP,    BTN_TR,  SEG_A, RIGHT},
        '{SEG_F, DOWN,  BTN_TL,  SEG_G, RIGHT},
        '{SEG_G, RIGHT, BTN_TL,  SEG_B, UP},
        '{SEG_G, RIGHT, BTN_TR,  SEG_C, DOWN},
        '{SEG_G, LEFT,  BTN_TL,  SEG_E, DOWN},
        '{SEG_G, LEFT,  BTN_TR,  SEG_F, UP}
    };

    localparam stim_t STIM [NUM_ROWS] = '{
        '{BTN_TL,   4'd2},  // Ignored while the start segment shows
        '{BTN_TR,   4'd0},
        '{BTN_TR,   4'd0},
        '{BTN_TR,   4'd0},
        '{BTN_FWD,  4'd0},
        '{BTN_TR,   4'd0},  // C down to D
        '{BTN_TR,   4'd0},
        '{BTN_TL,   4'd0},  // No entry for E heading up
        '{BTN_FWD,  4'd0},
        '{BTN_TR,   4'd0},
        '{BTN_DROP, 4'd0},
        '{BTN_TR,   4'd0},
        '{BTN_TR,   4'd0},
        '{BTN_TL,   4'd0},
        '{BTN_TL,   4'd0},
        '{BTN_TL,   4'd0},
        '{BTN_TL,   4'd0},  // Back over G which is already dark
        '{BTN_TR,   4'd1},  // Last lit segment goes dark
        '{BTN_NONE, 4'd2},
        '{BTN_TL,   4'd0}
    };

    logic       clk;
    logic       rst;
    buttons_t   btn;
    digit_sel_t digit;
    seg_mask_t  segments;

    row_t        rows [NUM_ROWS];
    game_state_t m_state;
    seg_idx_t    m_pos;
    heading_t    m_hd;
    seg_mask_t   m_dark;
    int          cycles;
    int          cycle_limit;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    snake_top #(
        .TICK_CYCLES (TICK_CYCLES),
        .SCAN_CYCLES (SCAN_CYCLES)
    ) snake_top_i (
        .clk      (clk),
        .rst      (rst),
        .btn      (btn),
        .digit    (digit),
        .segments (segments)
    );

    bind snake_top snake_asserts asserts_i (
        .clk      (clk),
        .rst      (rst),
        .digit    (digit),
        .segments (segments),
        .pulse    (pulse),
        .state    (game_i.state)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic find_move(input buttons_t b, output logic hit,
                             output seg_idx_t nseg, output heading_t nhd);
        hit = 1'b0;
        nseg = m_pos;
        nhd = m_hd;
        for (int i = 0; i < NUM_MOVES; i++) begin
            if (!hit && MOVES[i].seg == m_pos && MOVES[i].hd == m_hd
                && MOVES[i].btn == b) begin
                hit = 1'b1;
                nseg = MOVES[i].new_seg;
                nhd = MOVES[i].new_hd;
            end
        end
    endtask

    // Reference model of the game for one row
    task automatic predict_row(input stim_t s, output seg_mask_t face, output seg_mask_t care);
        logic     hit;
        seg_idx_t nseg;
        heading_t nhd;
        find_move(s.press, hit, nseg, nhd);
        case (m_state)
            INITIAL: begin
                if (s.wait_ticks >= `START_TICKS) m_state = MOVING;
            end
            MOVING: begin
                if (s.press.drop) begin
                    m_state = FALLING;
                    m_dark = '0;
                    m_dark[m_pos] = 1'b1;
                end else if (hit) begin
                    m_pos = nseg;
                    m_hd = nhd;
                end
            end
            default: begin
                if (hit) begin
                    m_pos = nseg;
                    m_hd = nhd;
                    m_dark[m_pos] = 1'b1;
                end
                // At least one tick passes before the display is sampled
                if (m_dark == '1) begin
                    m_state = INITIAL;
                    m_pos = SEG_G;
                    m_hd = LEFT;
                end
            end
        endcase
        care = '1;
        face = '1;
        face[m_pos] = 1'b0;
        if (m_state == FALLING) begin
            face = m_dark;
            care[m_pos] = 1'b0;
        end
    endtask

    task automatic press_button(input buttons_t b);
        btn = b;
        repeat (PRESS_CYCLES) @(negedge clk);
        btn = BTN_NONE;
        repeat (RELEASE_CYCLES) @(negedge clk);
    endtask

    // One full scan, then the next refresh of the rightmost digit
    task automatic check_display(input seg_mask_t face, input seg_mask_t care);
        repeat (SCAN_FULL) @(negedge clk);
        while (digit != 4'b1110) @(negedge clk);
        assert (((segments ^ face) & care) == '0)
            else report_failure($sformatf("ERR segments expected %h actual %h care %h",
                                          face, segments, care));
    endtask

    always @(negedge clk) begin
        if (!rst && digit[0]) begin
            assert (segments == `SEG_BLANK)
                else report_failure($sformatf("ERR segments expected %h actual %h on a blank digit",
                                              `SEG_BLANK, segments));
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            report_failure($sformatf("Timeout, the run did not finish within %0d cycles",
                                     cycle_limit));
        end
    end

    initial begin
        seg_mask_t face;
        seg_mask_t care;
        rst = 1'b1;
        btn = BTN_NONE;
        cycles = 0;
        m_state = INITIAL;
        m_pos = SEG_G;
        m_hd = LEFT;
        m_dark = '0;
        cycle_limit = 2 + 2 * SCAN_FULL + TIMEOUT_MARGIN;
        for (int i = 0; i < NUM_ROWS; i++) begin
            predict_row(STIM[i], face, care);
            rows[i] = '{STIM[i], face, care};
            cycle_limit += PRESS_CYCLES + RELEASE_CYCLES + 2 * SCAN_FULL
                           + STIM[i].wait_ticks * TICK_CYCLES;
        end

        repeat (2) @(negedge clk);
        assert (digit == '1)
            else report_failure($sformatf("ERR digit expected %h actual %h", 4'hf, digit));
        assert (segments == `SEG_BLANK)
            else report_failure($sformatf("ERR segments expected %h actual %h",
                                          `SEG_BLANK, segments));
        rst = 1'b0;

        // Start segment right after reset
        check_display(FACE_G, '1);

        for (int i = 0; i < NUM_ROWS; i++) begin
            press_button(rows[i].stim.press);
            repeat (rows[i].stim.wait_ticks * TICK_CYCLES) @(negedge clk);
            check_display(rows[i].face, rows[i].care);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
verilog/snake_pkg.sv
verilog/button_conditioner.sv
verilog/snake_path.sv
verilog/snake_game.sv
verilog/segment_scan.sv
verilog/snake_top.sv
dv/snake_asserts.sv
dv/snake_tb.sv

// File: include/snake_defines.svh
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// Segments A..G on one digit
`define SEG_COUNT 7

// Digits on the board
`define DIGIT_COUNT 4

// Consecutive high samples that count as a press
`define DEBOUNCE_LEN 4

// Game ticks spent showing the start segment
`define START_TICKS 2

// Active-low, so all ones is dark
`define SEG_BLANK 7'b111_1111

`endif

// File: run.sh
#!/usr/bin/env bash
# Compile and run the snake testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module snake_tb \
    -o snake_sim 2>&1 | tee build.log &&
    ./obj_dir/snake_sim 2>&1 | tee sim.log ||
    { echo "Build or simulation failed"; exit 1; }

grep -q "Test FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
echo "Simulation passed"
exit 0

// File: verilog/button_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

`include "snake_defines.svh"

module button_conditioner
    import snake_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  buttons_t btn,
    output buttons_t pulse
);

    localparam int N = $bits(buttons_t);

    logic [`DEBOUNCE_LEN-1:0] samples [N];
    logic [N-1:0]             raw;
    logic [N-1:0]             level;
    logic [N-1:0]             level_d;
    logic [N-1:0]             pulse_q;

    assign raw = btn;

    // Debounced once the whole window is high
    always_comb begin
        for (int i = 0; i < N; i++) begin
            level[i] = &samples[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N; i++) begin
                samples[i] <= '0;
            end
            level_d <= '0;
            pulse_q <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                samples[i] <= {samples[i][`DEBOUNCE_LEN-2:0], raw[i]};
            end
            level_d <= level;
            // Rising edge of the debounced level
            pulse_q <= level & ~level_d;
        end
    end

    assign pulse = pulse_q;

endmodule

`default_nettype wire

// File: verilog/segment_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "snake_defines.svh"

module segment_scan
    import snake_pkg::*;
#(
    parameter int SCAN_CYCLES = 100_000
) (
    input  logic       clk,
    input  logic       rst,
    input  seg_mask_t  face,
    output digit_sel_t digit,
    output seg_mask_t  segments
);

    localparam int SW = $clog2(SCAN_CYCLES);

    logic [SW-1:0] prescale;
    logic          step;
    digit_sel_t    digit_n;

    assign step = (prescale == SW'(SCAN_CYCLES - 1));

    // Rotate the single low bit leftwards, starting on the rightmost digit
    always_comb begin
        digit_n = digit;
        if (step) begin
            if (&digit) digit_n = ~digit_sel_t'(1);
            else digit_n = {digit[`DIGIT_COUNT-2:0], digit[`DIGIT_COUNT-1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prescale <= '0;
            digit <= '1;
            segments <= `SEG_BLANK;
        end else begin
            prescale <= step ? '0 : prescale + 1'b1;
            digit <= digit_n;
            // Only the rightmost digit shows the game
            segments <= digit_n[0] ? `SEG_BLANK : face;
        end
    end

endmodule

`default_nettype wire

// File: verilog/snake_game.sv
`timescale 1ns/1ps
`default_nettype none

`include "snake_defines.svh"

module snake_game
    import snake_pkg::*;
#(
    parameter int TICK_CYCLES = 50_000_000
) (
    input  logic      clk,
    input  logic      rst,
    input  buttons_t  pulse,
    output seg_mask_t face
);

    localparam int CW = $clog2(TICK_CYCLES);
    localparam int TW = $clog2(`START_TICKS + 1);

    game_state_t state;
    game_state_t state_n;
    logic [CW-1:0] cnt;
    logic [TW-1:0] ticks;
    logic          tick;
    seg_idx_t      pos;
    heading_t      heading;
    seg_idx_t      next_pos;
    heading_t      next_heading;
    logic          moved;
    // 1 marks an erased segment
    seg_mask_t     record;
    logic          blink;
    seg_mask_t     pos_mask;

    snake_path path_i (
        .pos          (pos),
        .heading      (heading),
        .pulse        (pulse),
        .next_pos     (next_pos),
        .next_heading (next_heading),
        .moved        (moved)
    );

    assign tick = (cnt == CW'(TICK_CYCLES - 1));
    assign pos_mask = seg_mask_t'(1) << pos;

    always_comb begin
        state_n = state;
        case (state)
            INITIAL: begin
                if (tick && ticks == TW'(`START_TICKS - 1)) state_n = MOVING;
            end
            MOVING: begin
                if (pulse.drop) state_n = FALLING;
            end
            FALLING: begin
                if (tick && &record) state_n = INITIAL;
            end
            default: begin
                state_n = INITIAL;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= INITIAL;
            cnt <= '0;
            ticks <= '0;
            pos <= SEG_G;
            heading <= LEFT;
            record <= '0;
            blink <= 1'b0;
        end else begin
            state <= state_n;

            // Tick timing starts over in every new state
            if (state_n != state || tick) cnt <= '0;
            else cnt <= cnt + 1'b1;

            if (state_n != state) ticks <= '0;
            else if (tick) ticks <= ticks + 1'b1;

            if (tick) blink <= ~blink;

            case (state)
                INITIAL: begin
                    pos <= SEG_G;
                    heading <= LEFT;
                end
                MOVING: begin
                    if (pulse.drop) begin
                        // Everything lit but the snake itself
                        record <= pos_mask;
                        blink <= 1'b0;
                    end else if (moved) begin
                        pos <= next_pos;
                        heading <= next_heading;
                    end
                end
                FALLING: begin
                    if (moved) begin
                        pos <= next_pos;
                        heading <= next_heading;
                        record[next_pos] <= 1'b1;
                    end
                end
                default: begin
                    pos <= SEG_G;
                end
            endcase
        end
    end

    always_comb begin
        if (state == FALLING) begin
            face = record;
            face[pos] = blink;
        end else begin
            face = ~pos_mask;
        end
    end

endmodule

`default_nettype wire

// File: verilog/snake_path.sv
`timescale 1ns/1ps
`default_nettype none

module snake_path
    import snake_pkg::*;
(
    input  seg_idx_t pos,
    input  heading_t heading,
    input  buttons_t pulse,
    output seg_idx_t next_pos,
    output heading_t next_heading,
    output logic     moved
);

    typedef struct packed {
        seg_idx_t pos;
        heading_t heading;
    } step_t;

    step_t nxt;
    logic  miss;

    // Within one segment, turn_left entries come first, then turn_right, then forward
    always_comb begin
        nxt = '{pos, heading};
        miss = 1'b0;
        case (pos)
            SEG_A: begin
                if (heading == LEFT && pulse.turn_left) nxt = '{SEG_F, DOWN};
                else if (heading == RIGHT && pulse.turn_right) nxt = '{SEG_B, DOWN};
                else miss = 1'b1;
            end
            SEG_B: begin
                if (heading == UP && pulse.turn_left) nxt = '{SEG_A, LEFT};
                else if (heading == DOWN && pulse.turn_right) nxt = '{SEG_G, LEFT};
                else if (heading == DOWN && pulse.forward) nxt = '{SEG_C, DOWN};
                else miss = 1'b1;
            end
            SEG_C: begin
                if (heading == UP && pulse.turn_left) nxt = '{SEG_G, LEFT};
                else if (heading == DOWN && pulse.turn_right) nxt = '{SEG_D, LEFT};
                else if (heading == UP && pulse.forward) nxt = '{SEG_B, UP};
                else miss = 1'b1;
            end
            SEG_D: begin
                if (heading == RIGHT && pulse.turn_left) nxt = '{SEG_C, UP};
                else if (heading == LEFT && pulse.turn_right) nxt = '{SEG_E, UP};
                else miss = 1'b1;
            end
            SEG_E: begin
                if (heading == DOWN && pulse.turn_left) nxt = '{SEG_D, RIGHT};
                else if (heading == UP && pulse.turn_right) nxt = '{SEG_G, RIGHT};
                else if (heading == UP && pulse.forward) nxt = '{SEG_F, UP};
                else miss = 1'b1;
            end
            SEG_F: begin
                if (heading == DOWN && pulse.turn_left) nxt = '{SEG_G, RIGHT};
                else if (heading == UP && pulse.turn_right) nxt = '{SEG_A, RIGHT};
                else miss = 1'b1;
            end
            SEG_G: begin
                if (heading == RIGHT && pulse.turn_left) nxt = '{SEG_B, UP};
                else if (heading == LEFT && pulse.turn_left) nxt = '{SEG_E, DOWN};
                else if (heading == RIGHT && pulse.turn_right) nxt = '{SEG_C, DOWN};
                else if (heading == LEFT && pulse.turn_right) nxt = '{SEG_F, UP};
                else miss = 1'b1;
            end
            default: begin
                miss = 1'b1;
            end
        endcase
    end

    assign next_pos = nxt.pos;
    assign next_heading = nxt.heading;
    assign moved = ~miss;

endmodule

`default_nettype wire

// File: verilog/snake_pkg.sv
`default_nettype none

package snake_pkg;

`include "snake_defines.svh"

    // Active low, bit 0 is segment A
    typedef logic [`SEG_COUNT-1:0] seg_mask_t;

    typedef logic [2:0] seg_idx_t;

    // Active low, bit 0 is the rightmost digit
    typedef logic [`DIGIT_COUNT-1:0] digit_sel_t;

    typedef enum logic [1:0] {RIGHT, LEFT, UP, DOWN} heading_t;

    typedef enum logic [1:0] {INITIAL, MOVING, FALLING} game_state_t;

    typedef struct packed {
        logic turn_right;
        logic turn_left;
        logic forward;
        logic drop;
    } buttons_t;

    localparam seg_idx_t SEG_A = 3'd0;
    localparam seg_idx_t SEG_B = 3'd1;
    localparam seg_idx_t SEG_C = 3'd2;
    localparam seg_idx_t SEG_D = 3'd3;
    localparam seg_idx_t SEG_E = 3'd4;
    localparam seg_idx_t SEG_F = 3'd5;
    localparam seg_idx_t SEG_G = 3'd6;

endpackage

`default_nettype wire

// File: verilog/snake_top.sv
`timescale 1ns/1ps
`default_nettype none

module snake_top
    import snake_pkg::*;
#(
    parameter int TICK_CYCLES = 50_000_000,
    parameter int SCAN_CYCLES = 100_000
) (
    input  logic       clk,
    input  logic       rst,
    input  buttons_t   btn,
    output digit_sel_t digit,
    output seg_mask_t  segments
);

    buttons_t  pulse;
    seg_mask_t face;

    button_conditioner cond_i (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn),
        .pulse (pulse)
    );

    snake_game #(
        .TICK_CYCLES (TICK_CYCLES)
    ) game_i (
        .clk   (clk),
        .rst   (rst),
        .pulse (pulse),
        .face  (face)
    );

    segment_scan #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) scan_i (
        .clk      (clk),
        .rst      (rst),
        .face     (face),
        .digit    (digit),
        .segments (segments)
    );

endmodule

`default_nettype wire
